/* Bender.yml */
package:
  name: eth_regs

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/eth_regs_pkg.sv
      - hdl/eth_apb_slave.sv
      - hdl/eth_cfg_regs.sv
      - hdl/pulse_sync.sv
      - hdl/eth_clr_dispatch.sv
      - hdl/eth_regs_wrap.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_eth_regs.sv

/* hdl/eth_apb_slave.sv */
/*
 * APB slave front end
 * turns each transfer into one access record, returns read data
 */
`default_nettype none

module eth_apb_slave
(
	input  logic                      reg_clk,
	input  logic                      reg_rstn,
	input  logic [31:0]               paddr,
	input  logic                      pwrite,
	input  logic                      psel,
	input  logic                      penable,
	input  logic [31:0]               pwdata,
	input  logic [31:0]               rdata,
	output eth_regs_pkg::reg_access_t access,
	output logic [31:0]               prdata
);

	import eth_regs_pkg::*;

	logic setup_q;
	logic access_phase;

	// setup phase seen on the previous cycle
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
			setup_q <= 1'b0;
		else
			setup_q <= psel & ~penable;
	end

	// penable without a setup cycle before it is dropped
	assign access_phase = psel & penable & setup_q;

	always_comb
	begin
		access.addr  = paddr[7:0];
		access.wdata = pwdata;
		if (!access_phase)
			access.op = REG_IDLE;
		else if (pwrite)
			access.op = REG_WRITE;
		else
			access.op = REG_READ;
	end

	// read data only in a read access phase
	assign prdata = (access.op == REG_READ) ? rdata : 32'h0;

endmodule

`default_nettype wire

/* hdl/eth_cfg_regs.sv */
/*
 * Ethernet register file
 * shadow and live settings, FIFO strobes, interrupts and readback
 */
`default_nettype none

`include "eth_regs_defines.svh"

module eth_cfg_regs
(
	input  logic                      reg_clk,
	input  logic                      reg_rstn,
	input  eth_regs_pkg::reg_access_t access,
	output logic [31:0]               rdata,
	output logic [22:0]               tx_data,
	output logic                      tx_fifo_wr,
	input  logic [15:0]               rx_data,
	output logic                      rx_fifo_rd,
	input  logic [2:0]                tx_fifo_num,
	input  logic [2:0]                rx_fifo_num,
	output logic [5:0]                int_en,
	output logic [5:0]                int_clr,
	input  logic [5:0]                int_sta,
	output logic                      irq,
	output eth_regs_pkg::sma_cfg_t    sma_cfg,
	output eth_regs_pkg::mac_cfg_t    mac_cfg,
	output eth_regs_pkg::clr_req_t    clr_req
);

	import eth_regs_pkg::*;

	logic        wr;
	logic [31:0] wd;
	logic        wr_sma_ctrl;
	logic        wr_mac_ctrl;
	logic        wr_int_sta;
	logic        sma_update_q;
	logic        mac_update_q;
	sma_cfg_t    sma_shadow;
	logic [47:0] macaddr_shadow;
	logic        duplex_shadow;
	logic [1:0]  pre_byte_shadow;
	logic [5:0]  interval_byte_shadow;
	logic [15:0] rx_data_q;

	assign wr          = (access.op == REG_WRITE);
	assign wd          = access.wdata;
	assign wr_sma_ctrl = wr && (access.addr == `ETH_REG_SMA_CTRL);
	assign wr_mac_ctrl = wr && (access.addr == `ETH_REG_MAC_CTRL);
	assign wr_int_sta  = wr && (access.addr == `ETH_REG_INT_STA);

	// ====================
	// shadow copies
	// ====================

	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			sma_shadow           <= '{`ETH_CLKDIV_RST, 5'h0, `ETH_INTERVAL_BIT_RST};
			macaddr_shadow       <= 48'h0;
			duplex_shadow        <= 1'b0;
			pre_byte_shadow      <= 2'h0;
			interval_byte_shadow <= 6'h0;
			int_en               <= 6'h0;
		end
		else if (wr)
		begin
			case (access.addr)
				`ETH_REG_SMA_CFG:
				begin
					sma_shadow.clkdiv       <= wd[`ETH_SMA_CFG_CLKDIV];
					sma_shadow.phyadr       <= wd[`ETH_SMA_CFG_PHYADR];
					sma_shadow.interval_bit <= wd[`ETH_SMA_CFG_INTERVAL_BIT];
				end
				`ETH_REG_MAC_ADDRL: macaddr_shadow[31:0] <= wd;
				`ETH_REG_MAC_ADDRH: macaddr_shadow[47:32] <= wd[15:0];
				`ETH_REG_MAC_CFG:
				begin
					duplex_shadow        <= wd[`ETH_MAC_CFG_DUPLEX];
					pre_byte_shadow      <= wd[`ETH_MAC_CFG_PRE_BYTE];
					interval_byte_shadow <= wd[`ETH_MAC_CFG_INTERVAL_BYTE];
				end
				`ETH_REG_INT_EN: int_en <= wd[`ETH_INT_BITS];
				default: ;
			endcase
		end
	end

	// ====================
	// update and live copies
	// ====================

	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			sma_update_q <= 1'b0;
			mac_update_q <= 1'b0;
			tx_fifo_wr   <= 1'b0;
		end
		else
		begin
			sma_update_q <= wr_sma_ctrl & wd[`ETH_SMA_CTRL_UPDATE];
			mac_update_q <= wr_mac_ctrl & wd[`ETH_MAC_CTRL_UPDATE];
			tx_fifo_wr   <= wr && (access.addr == `ETH_REG_TX_DATA);
		end
	end

	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
			sma_cfg <= '{`ETH_CLKDIV_RST, 5'h0, `ETH_INTERVAL_BIT_RST};
		else if (sma_update_q)
			sma_cfg <= sma_shadow;
	end

	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
			mac_cfg <= '0;
		else
		begin
			if (mac_update_q)
			begin
				mac_cfg.macaddr       <= macaddr_shadow;
				mac_cfg.duplex        <= duplex_shadow;
				mac_cfg.pre_byte      <= pre_byte_shadow;
				mac_cfg.interval_byte <= interval_byte_shadow;
			end
			// enable levels skip the shadow
			if (wr_mac_ctrl)
			begin
				mac_cfg.tx_enable <= wd[`ETH_MAC_CTRL_TX_ENABLE];
				mac_cfg.rx_enable <= wd[`ETH_MAC_CTRL_RX_ENABLE];
			end
		end
	end

	// ====================
	// fifo data path
	// ====================

	always_ff @(posedge reg_clk)
	begin
		if (wr && (access.addr == `ETH_REG_TX_DATA))
			tx_data <= wd[`ETH_TX_DATA_BITS];
		rx_data_q <= rx_data;
	end

	assign rx_fifo_rd = (access.op == REG_READ) && (access.addr == `ETH_REG_RX_DATA);

	// write-one pulses, high for the access cycle
	assign int_clr          = wr_int_sta ? wd[`ETH_INT_BITS] : 6'h0;
	assign irq              = |(int_sta & int_en);
	assign clr_req.tx_fifo  = wr_sma_ctrl & wd[`ETH_SMA_CTRL_TX_FIFO_CLR];
	assign clr_req.rx_fifo  = wr_sma_ctrl & wd[`ETH_SMA_CTRL_RX_FIFO_CLR];
	assign clr_req.master   = wr_sma_ctrl & wd[`ETH_SMA_CTRL_MASTER_CLR];
	assign clr_req.tx_logic = wr_mac_ctrl & wd[`ETH_MAC_CTRL_TX_LOGIC_CLR];
	assign clr_req.rx_logic = wr_mac_ctrl & wd[`ETH_MAC_CTRL_RX_LOGIC_CLR];

	// ====================
	// readback
	// ====================

	always_comb
	begin
		rdata = 32'h0;
		case (access.addr)
			`ETH_REG_SMA_CFG:
			begin
				rdata[`ETH_SMA_CFG_CLKDIV]       = sma_shadow.clkdiv;
				rdata[`ETH_SMA_CFG_PHYADR]       = sma_shadow.phyadr;
				rdata[`ETH_SMA_CFG_INTERVAL_BIT] = sma_shadow.interval_bit;
			end
			`ETH_REG_RX_DATA: rdata[`ETH_RX_DATA_BITS] = rx_data_q;
			`ETH_REG_FIFO_STAT:
			begin
				rdata[`ETH_FIFO_STAT_TX_NUM] = tx_fifo_num;
				rdata[`ETH_FIFO_STAT_RX_NUM] = rx_fifo_num;
			end
			`ETH_REG_INT_EN:  rdata[`ETH_INT_BITS] = int_en;
			`ETH_REG_INT_STA: rdata[`ETH_INT_BITS] = int_sta;
			`ETH_REG_MAC_CTRL:
			begin
				rdata[`ETH_MAC_CTRL_TX_ENABLE] = mac_cfg.tx_enable;
				rdata[`ETH_MAC_CTRL_RX_ENABLE] = mac_cfg.rx_enable;
			end
			`ETH_REG_MAC_ADDRL: rdata = macaddr_shadow[31:0];
			`ETH_REG_MAC_ADDRH: rdata[15:0] = macaddr_shadow[47:32];
			`ETH_REG_MAC_CFG:
			begin
				rdata[`ETH_MAC_CFG_DUPLEX]        = duplex_shadow;
				rdata[`ETH_MAC_CFG_PRE_BYTE]      = pre_byte_shadow;
				rdata[`ETH_MAC_CFG_INTERVAL_BYTE] = interval_byte_shadow;
			end
			// SMA_CTRL and TX_DATA read as zero
			default: rdata = 32'h0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/eth_clr_dispatch.sv */
/*
 * Clear dispatcher
 * local SMA clears registered once, logic clears sent across domains
 */
`default_nettype none

module eth_clr_dispatch
(
	input  logic                   reg_clk,
	input  logic                   reg_rstn,
	input  logic                   pe_tx_clk,
	input  logic                   pe_tx_rstn,
	input  logic                   pe_rx_clk,
	input  logic                   pe_rx_rstn,
	input  eth_regs_pkg::clr_req_t clr_req,
	output eth_regs_pkg::clr_req_t sma_clr,
	output logic                   tx_logic_clr,
	output logic                   rx_logic_clr
);

	import eth_regs_pkg::*;

	clr_req_t sma_clr_q;

	// cuts the path from the APB decode
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
			sma_clr_q <= '0;
		else
			sma_clr_q <= '{clr_req.tx_fifo, clr_req.rx_fifo, clr_req.master, 1'b0, 1'b0};
	end

	assign sma_clr = sma_clr_q;

	pulse_sync #(.WIDTH(1)) u_tx_logic_sync
	(
		.src_clk   (reg_clk),
		.src_rstn  (reg_rstn),
		.des_clk   (pe_tx_clk),
		.des_rstn  (pe_tx_rstn),
		.src_pulse (clr_req.tx_logic),
		.des_pulse (tx_logic_clr)
	);

	pulse_sync #(.WIDTH(1)) u_rx_logic_sync
	(
		.src_clk   (reg_clk),
		.src_rstn  (reg_rstn),
		.des_clk   (pe_rx_clk),
		.des_rstn  (pe_rx_rstn),
		.src_pulse (clr_req.rx_logic),
		.des_pulse (rx_logic_clr)
	);

endmodule

`default_nettype wire

/* hdl/eth_regs_pkg.sv */
/*
 * Ethernet register block types
 * access record, configuration groups and clear requests
 */
`default_nettype none

package eth_regs_pkg;

	// ====================
	// bus decode
	// ====================

	typedef enum logic [1:0]
	{
		REG_IDLE,
		REG_WRITE,
		REG_READ
	} reg_op_e;

	// one decoded APB transfer
	typedef struct packed
	{
		reg_op_e     op;
		logic [7:0]  addr;
		logic [31:0] wdata;
	} reg_access_t;

	// ====================
	// configuration groups
	// ====================

	typedef struct packed
	{
		logic [7:0] clkdiv;
		logic [4:0] phyadr;
		logic [7:0] interval_bit;
	} sma_cfg_t;

	// enables are levels, everything else goes through the shadow
	typedef struct packed
	{
		logic [47:0] macaddr;
		logic        duplex;
		logic [1:0]  pre_byte;
		logic [5:0]  interval_byte;
		logic        tx_enable;
		logic        rx_enable;
	} mac_cfg_t;

	// write-one clear commands
	typedef struct packed
	{
		logic tx_fifo;
		logic rx_fifo;
		logic master;
		logic tx_logic;
		logic rx_logic;
	} clr_req_t;

endpackage

`default_nettype wire

/* hdl/eth_regs_wrap.sv */
/*
 * Ethernet register block top
 * APB decoder, register file and clear dispatcher
 */
`default_nettype none

module eth_regs_wrap
(
	input  logic                   reg_clk,
	input  logic                   reg_rstn,
	input  logic                   pe_tx_clk,
	input  logic                   pe_tx_rstn,
	input  logic                   pe_rx_clk,
	input  logic                   pe_rx_rstn,
	// apb
	input  logic [31:0]            paddr,
	input  logic                   pwrite,
	input  logic                   psel,
	input  logic                   penable,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	// sma fifo and interrupts
	output logic [22:0]            tx_data,
	output logic                   tx_fifo_wr,
	input  logic [15:0]            rx_data,
	output logic                   rx_fifo_rd,
	input  logic [2:0]             tx_fifo_num,
	input  logic [2:0]             rx_fifo_num,
	output logic [5:0]             int_en,
	output logic [5:0]             int_clr,
	input  logic [5:0]             int_sta,
	output logic                   irq,
	// settings and clears
	output eth_regs_pkg::sma_cfg_t sma_cfg,
	output eth_regs_pkg::mac_cfg_t mac_cfg,
	output eth_regs_pkg::clr_req_t sma_clr,
	output logic                   tx_logic_clr,
	output logic                   rx_logic_clr
);

	import eth_regs_pkg::*;

	reg_access_t access;
	logic [31:0] rdata;
	clr_req_t    clr_req;

	eth_apb_slave u_eth_apb_slave
	(
		.reg_clk  (reg_clk),
		.reg_rstn (reg_rstn),
		.paddr    (paddr),
		.pwrite   (pwrite),
		.psel     (psel),
		.penable  (penable),
		.pwdata   (pwdata),
		.rdata    (rdata),
		.access   (access),
		.prdata   (prdata)
	);

	eth_cfg_regs u_eth_cfg_regs
	(
		.reg_clk     (reg_clk),
		.reg_rstn    (reg_rstn),
		.access      (access),
		.rdata       (rdata),
		.tx_data     (tx_data),
		.tx_fifo_wr  (tx_fifo_wr),
		.rx_data     (rx_data),
		.rx_fifo_rd  (rx_fifo_rd),
		.tx_fifo_num (tx_fifo_num),
		.rx_fifo_num (rx_fifo_num),
		.int_en      (int_en),
		.int_clr     (int_clr),
		.int_sta     (int_sta),
		.irq         (irq),
		.sma_cfg     (sma_cfg),
		.mac_cfg     (mac_cfg),
		.clr_req     (clr_req)
	);

	eth_clr_dispatch u_eth_clr_dispatch
	(
		.reg_clk      (reg_clk),
		.reg_rstn     (reg_rstn),
		.pe_tx_clk    (pe_tx_clk),
		.pe_tx_rstn   (pe_tx_rstn),
		.pe_rx_clk    (pe_rx_clk),
		.pe_rx_rstn   (pe_rx_rstn),
		.clr_req      (clr_req),
		.sma_clr      (sma_clr),
		.tx_logic_clr (tx_logic_clr),
		.rx_logic_clr (rx_logic_clr)
	);

endmodule

`default_nettype wire

/* hdl/pulse_sync.sv */
/*
 * Toggle pulse synchronizer
 * one source-cycle pulse becomes one destination-cycle pulse
 */
`default_nettype none

module pulse_sync
#(
	parameter int WIDTH = 1
)
(
	input  logic             src_clk,
	input  logic             src_rstn,
	input  logic             des_clk,
	input  logic             des_rstn,
	input  logic [WIDTH-1:0] src_pulse,
	output logic [WIDTH-1:0] des_pulse
);

	logic [WIDTH-1:0] src_toggle;
	logic [WIDTH-1:0] des_meta;
	logic [WIDTH-1:0] des_sync;
	logic [WIDTH-1:0] des_sync_d;

	// source side, flip once per pulse
	always_ff @(posedge src_clk or negedge src_rstn)
	begin
		if (!src_rstn)
			src_toggle <= '0;
		else
			src_toggle <= src_toggle ^ src_pulse;
	end

	// two-flop synchronizer plus one stage for the edge detect
	always_ff @(posedge des_clk or negedge des_rstn)
	begin
		if (!des_rstn)
		begin
			des_meta   <= '0;
			des_sync   <= '0;
			des_sync_d <= '0;
		end
		else
		begin
			des_meta   <= src_toggle;
			des_sync   <= des_meta;
			des_sync_d <= des_sync;
		end
	end

	// either toggle edge marks a pulse
	assign des_pulse = des_sync ^ des_sync_d;

endmodule

`default_nettype wire

/* include/eth_regs_defines.svh */
/*
 * Ethernet register block address map, field positions and reset values
 */
`ifndef ETH_REGS_DEFINES_SVH
`define ETH_REGS_DEFINES_SVH

// byte offsets, one 32-bit word each
`define ETH_REG_SMA_CTRL          8'h00
`define ETH_REG_SMA_CFG           8'h04
`define ETH_REG_TX_DATA           8'h08
`define ETH_REG_RX_DATA           8'h0C
`define ETH_REG_FIFO_STAT         8'h10
`define ETH_REG_INT_EN            8'h14
`define ETH_REG_INT_STA           8'h18
`define ETH_REG_MAC_CTRL          8'h20
`define ETH_REG_MAC_ADDRL         8'h24
`define ETH_REG_MAC_ADDRH         8'h28
`define ETH_REG_MAC_CFG           8'h2C

// sma reset values
`define ETH_CLKDIV_RST            8'd4
`define ETH_INTERVAL_BIT_RST      8'd3

// SMA_CTRL, write-one bits
`define ETH_SMA_CTRL_UPDATE       0
`define ETH_SMA_CTRL_TX_FIFO_CLR  1
`define ETH_SMA_CTRL_RX_FIFO_CLR  2
`define ETH_SMA_CTRL_MASTER_CLR   3

// SMA_CFG fields
`define ETH_SMA_CFG_CLKDIV        7:0
`define ETH_SMA_CFG_PHYADR        12:8
`define ETH_SMA_CFG_INTERVAL_BIT  23:16

// data and status fields
`define ETH_TX_DATA_BITS          22:0
`define ETH_RX_DATA_BITS          15:0
`define ETH_FIFO_STAT_TX_NUM      2:0
`define ETH_FIFO_STAT_RX_NUM      6:4
`define ETH_INT_BITS              5:0

// MAC_CTRL bits
`define ETH_MAC_CTRL_UPDATE       0
`define ETH_MAC_CTRL_TX_LOGIC_CLR 1
`define ETH_MAC_CTRL_RX_LOGIC_CLR 2
`define ETH_MAC_CTRL_TX_ENABLE    4
`define ETH_MAC_CTRL_RX_ENABLE    5

// MAC_CFG fields
`define ETH_MAC_CFG_DUPLEX        0
`define ETH_MAC_CFG_PRE_BYTE      5:4
`define ETH_MAC_CFG_INTERVAL_BYTE 13:8

`endif

/* sim/tb_eth_regs.sv */
/*
 * Ethernet register block testbench
 * directed APB tests over settings, FIFO access, interrupts and clears
 */
`default_nettype none

`include "eth_regs_defines.svh"

module tb_eth_regs;

	import eth_regs_pkg::*;

	// about 60 transfers of 3 cycles plus waits and a wide margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic        reg_clk;
	logic        reg_rstn;
	logic        pe_tx_clk;
	logic        pe_tx_rstn;
	logic        pe_rx_clk;
	logic        pe_rx_rstn;
	logic [31:0] paddr;
	logic        pwrite;
	logic        psel;
	logic        penable;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic [22:0] tx_data;
	logic        tx_fifo_wr;
	logic [15:0] rx_data;
	logic        rx_fifo_rd;
	logic [2:0]  tx_fifo_num;
	logic [2:0]  rx_fifo_num;
	logic [5:0]  int_en;
	logic [5:0]  int_clr;
	logic [5:0]  int_sta;
	logic        irq;
	sma_cfg_t    sma_cfg;
	mac_cfg_t    mac_cfg;
	clr_req_t    sma_clr;
	logic        tx_logic_clr;
	logic        rx_logic_clr;

	integer      seed = 32'h55e7af65;
	int          cycle_cnt = 0;
	int          tx_wr_cnt = 0;
	int          rx_rd_cnt = 0;
	int          int_clr_cnt = 0;
	logic [5:0]  int_clr_seen = 6'h0;
	int          sma_tx_cnt = 0;
	int          sma_rx_cnt = 0;
	int          sma_master_cnt = 0;
	int          tx_clr_cnt = 0;
	int          rx_clr_cnt = 0;

	eth_regs_wrap eth_regs_wrap_inst
	(
		.reg_clk      (reg_clk),
		.reg_rstn     (reg_rstn),
		.pe_tx_clk    (pe_tx_clk),
		.pe_tx_rstn   (pe_tx_rstn),
		.pe_rx_clk    (pe_rx_clk),
		.pe_rx_rstn   (pe_rx_rstn),
		.paddr        (paddr),
		.pwrite       (pwrite),
		.psel         (psel),
		.penable      (penable),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.tx_data      (tx_data),
		.tx_fifo_wr   (tx_fifo_wr),
		.rx_data      (rx_data),
		.rx_fifo_rd   (rx_fifo_rd),
		.tx_fifo_num  (tx_fifo_num),
		.rx_fifo_num  (rx_fifo_num),
		.int_en       (int_en),
		.int_clr      (int_clr),
		.int_sta      (int_sta),
		.irq          (irq),
		.sma_cfg      (sma_cfg),
		.mac_cfg      (mac_cfg),
		.sma_clr      (sma_clr),
		.tx_logic_clr (tx_logic_clr),
		.rx_logic_clr (rx_logic_clr)
	);

	// ====================
	// clocks and monitors
	// ====================

	initial
	begin
		reg_clk = 1'b0;
		forever #2 reg_clk = ~reg_clk;
	end

	initial
	begin
		pe_tx_clk = 1'b0;
		forever #3 pe_tx_clk = ~pe_tx_clk;
	end

	initial
	begin
		pe_rx_clk = 1'b0;
		forever #5 pe_rx_clk = ~pe_rx_clk;
	end

	// strobes counted mid-cycle while stable
	always @(negedge reg_clk)
	begin
		if (tx_fifo_wr)
			tx_wr_cnt = tx_wr_cnt + 1;
		if (rx_fifo_rd)
			rx_rd_cnt = rx_rd_cnt + 1;
		if (int_clr != 6'h0)
		begin
			int_clr_cnt  = int_clr_cnt + 1;
			int_clr_seen = int_clr_seen | int_clr;
		end
		if (sma_clr.tx_fifo)
			sma_tx_cnt = sma_tx_cnt + 1;
		if (sma_clr.rx_fifo)
			sma_rx_cnt = sma_rx_cnt + 1;
		if (sma_clr.master)
			sma_master_cnt = sma_master_cnt + 1;
	end

	always @(negedge pe_tx_clk)
	begin
		if (tx_logic_clr)
			tx_clr_cnt = tx_clr_cnt + 1;
	end

	always @(negedge pe_rx_clk)
	begin
		if (rx_logic_clr)
			rx_clr_cnt = rx_clr_cnt + 1;
	end

	always @(posedge reg_clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			report_failure($sformatf("timeout, the run hung after %0d reg_clk cycles", cycle_cnt));
	end

	// ====================
	// helpers
	// ====================

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			report_failure($sformatf("Fail time=%0t %s: got 0x%0h expected 0x%0h",
				$time, name, actual, expected));
	endtask

	// setup and access cycles up to the access edge
	task automatic apb_transfer(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rd);
		@(posedge reg_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= {24'h0, addr};
		pwdata  <= wdata;
		@(posedge reg_clk);
		penable <= 1'b1;
		@(negedge reg_clk);
		rd = prdata;
		@(posedge reg_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, wdata, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rd);
		apb_transfer(1'b0, addr, 32'h0, rd);
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] rd;
		apb_read(addr, rd);
		check_value($sformatf("prdata @0x%02h", addr), rd, expected);
	endtask

	task automatic clear_counts();
		@(posedge reg_clk);
		tx_wr_cnt      = 0;
		rx_rd_cnt      = 0;
		int_clr_cnt    = 0;
		int_clr_seen   = 6'h0;
		sma_tx_cnt     = 0;
		sma_rx_cnt     = 0;
		sma_master_cnt = 0;
		tx_clr_cnt     = 0;
		rx_clr_cnt     = 0;
	endtask

	// ====================
	// tests
	// ====================

	task automatic test_reset_values();
		logic [7:0]  addrs [11];
		logic [31:0] exps [11];
		sma_cfg_t    sma_rst;
		addrs = '{`ETH_REG_SMA_CTRL, `ETH_REG_SMA_CFG, `ETH_REG_TX_DATA, `ETH_REG_RX_DATA,
			`ETH_REG_FIFO_STAT, `ETH_REG_INT_EN, `ETH_REG_INT_STA, `ETH_REG_MAC_CTRL,
			`ETH_REG_MAC_ADDRL, `ETH_REG_MAC_ADDRH, `ETH_REG_MAC_CFG};
		exps  = '{32'h0, {8'h0, `ETH_INTERVAL_BIT_RST, 8'h0, `ETH_CLKDIV_RST}, 32'h0, 32'h0,
			32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
		sma_rst = '{`ETH_CLKDIV_RST, 5'h0, `ETH_INTERVAL_BIT_RST};
		@(negedge reg_clk);
		check_value("sma_cfg", sma_cfg, sma_rst);
		check_value("mac_cfg", mac_cfg, 59'h0);
		check_value("tx_fifo_wr", tx_fifo_wr, 0);
		check_value("rx_fifo_rd", rx_fifo_rd, 0);
		check_value("int_en", int_en, 0);
		check_value("int_clr", int_clr, 0);
		check_value("sma_clr", sma_clr, 0);
		check_value("tx_logic_clr", tx_logic_clr, 0);
		check_value("rx_logic_clr", rx_logic_clr, 0);
		check_value("irq", irq, 0);
		for (int i = 0; i < 11; i++)
			read_expect(addrs[i], exps[i]);
	endtask

	// penable with no setup cycle in front is no transfer
	task automatic test_lone_penable();
		@(posedge reg_clk);
		psel    <= 1'b1;
		penable <= 1'b1;
		pwrite  <= 1'b0;
		paddr   <= {24'h0, `ETH_REG_SMA_CFG};
		@(negedge reg_clk);
		check_value("prdata without setup", prdata, 32'h0);
		@(posedge reg_clk);
		pwrite  <= 1'b1;
		paddr   <= {24'h0, `ETH_REG_INT_EN};
		pwdata  <= 32'h3F;
		@(posedge reg_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		@(negedge reg_clk);
		check_value("int_en after write without setup", int_en, 0);
	endtask

	task automatic test_shadow_update();
		logic [31:0] sma_wd;
		logic [31:0] addrl;
		logic [31:0] addrh;
		logic [31:0] cfg_wd;
		sma_cfg_t    sma_rst;
		sma_cfg_t    sma_exp;
		mac_cfg_t    mac_exp;
		sma_wd  = $random(seed);
		addrl   = $random(seed);
		addrh   = $random(seed);
		cfg_wd  = $random(seed);
		sma_rst = '{`ETH_CLKDIV_RST, 5'h0, `ETH_INTERVAL_BIT_RST};
		sma_exp = '{sma_wd[7:0], sma_wd[12:8], sma_wd[23:16]};
		mac_exp = '{{addrh[15:0], addrl}, cfg_wd[0], cfg_wd[5:4], cfg_wd[13:8], 1'b1, 1'b0};
		apb_write(`ETH_REG_SMA_CFG, sma_wd);
		apb_write(`ETH_REG_MAC_ADDRL, addrl);
		apb_write(`ETH_REG_MAC_ADDRH, addrh);
		apb_write(`ETH_REG_MAC_CFG, cfg_wd);
		@(negedge reg_clk);
		check_value("sma_cfg before update", sma_cfg, sma_rst);
		check_value("mac_cfg before update", mac_cfg, 59'h0);
		read_expect(`ETH_REG_SMA_CFG, sma_wd & 32'h00FF_1FFF);
		read_expect(`ETH_REG_MAC_ADDRL, addrl);
		read_expect(`ETH_REG_MAC_ADDRH, addrh & 32'h0000_FFFF);
		read_expect(`ETH_REG_MAC_CFG, cfg_wd & 32'h0000_3F31);
		// live copy loads one cycle after the access edge
		apb_write(`ETH_REG_SMA_CTRL, 32'h1 << `ETH_SMA_CTRL_UPDATE);
		@(negedge reg_clk);
		check_value("sma_cfg at access edge", sma_cfg, sma_rst);
		@(negedge reg_clk);
		check_value("sma_cfg after update", sma_cfg, sma_exp);
		apb_write(`ETH_REG_MAC_CTRL,
			(32'h1 << `ETH_MAC_CTRL_UPDATE) | (32'h1 << `ETH_MAC_CTRL_TX_ENABLE));
		@(negedge reg_clk);
		check_value("mac_cfg.tx_enable", mac_cfg.tx_enable, 1);
		check_value("mac_cfg.rx_enable", mac_cfg.rx_enable, 0);
		check_value("mac_cfg.macaddr at access edge", mac_cfg.macaddr, 48'h0);
		@(negedge reg_clk);
		check_value("mac_cfg after update", mac_cfg, mac_exp);
		// enables only without update
		apb_write(`ETH_REG_MAC_CTRL, 32'h1 << `ETH_MAC_CTRL_RX_ENABLE);
		@(negedge reg_clk);
		check_value("mac_cfg.tx_enable", mac_cfg.tx_enable, 0);
		check_value("mac_cfg.rx_enable", mac_cfg.rx_enable, 1);
		check_value("mac_cfg.macaddr", mac_cfg.macaddr, mac_exp.macaddr);
		read_expect(`ETH_REG_MAC_CTRL, 32'h1 << `ETH_MAC_CTRL_RX_ENABLE);
	endtask

	task automatic test_fifo_access();
		logic [31:0] tx_wd;
		logic [15:0] rx_val;
		logic [2:0]  tn;
		logic [2:0]  rn;
		tx_wd  = $random(seed);
		rx_val = $random(seed);
		tn     = $random(seed);
		rn     = $random(seed);
		clear_counts();
		apb_write(`ETH_REG_TX_DATA, tx_wd);
		@(negedge reg_clk);
		check_value("tx_fifo_wr", tx_fifo_wr, 1);
		check_value("tx_data", tx_data, tx_wd[22:0]);
		repeat (3) @(posedge reg_clk);
		check_value("tx_fifo_wr cycles", tx_wr_cnt, 1);
		rx_data <= rx_val;
		read_expect(`ETH_REG_RX_DATA, {16'h0, rx_val});
		repeat (2) @(posedge reg_clk);
		check_value("rx_fifo_rd cycles", rx_rd_cnt, 1);
		tx_fifo_num <= tn;
		rx_fifo_num <= rn;
		read_expect(`ETH_REG_FIFO_STAT, {25'h0, rn, 1'b0, tn});
	endtask

	task automatic test_interrupts();
		logic [5:0] en;
		logic [5:0] sta;
		logic [5:0] clr;
		logic [5:0] hit;
		int         pos;
		repeat (4)
		begin
			en  = $random(seed);
			sta = $random(seed);
			clr = $random(seed);
			pos = {$random(seed)} % 6;
			hit = 6'h1 << pos;
			// at least one enabled source
			en  = en | hit;
			if (clr == 6'h0)
				clr = 6'h01;
			apb_write(`ETH_REG_INT_EN, {26'h0, en});
			// pending only on masked sources
			int_sta <= sta & ~en;
			@(negedge reg_clk);
			check_value("int_en", int_en, en);
			check_value("irq with masked status", irq, 0);
			@(posedge reg_clk);
			int_sta <= sta | hit;
			@(negedge reg_clk);
			check_value("irq with enabled status", irq, 1);
			read_expect(`ETH_REG_INT_STA, {26'h0, sta | hit});
			read_expect(`ETH_REG_INT_EN, {26'h0, en});
			clear_counts();
			apb_write(`ETH_REG_INT_STA, {26'h0, clr});
			@(negedge reg_clk);
			check_value("int_clr after access", int_clr, 0);
			@(posedge reg_clk);
			check_value("int_clr cycles", int_clr_cnt, 1);
			check_value("int_clr bits", int_clr_seen, clr);
		end
	endtask

	task automatic test_sma_clears();
		clr_req_t exp;
		for (int b = `ETH_SMA_CTRL_TX_FIFO_CLR; b <= `ETH_SMA_CTRL_MASTER_CLR; b++)
		begin
			exp = '{b == `ETH_SMA_CTRL_TX_FIFO_CLR, b == `ETH_SMA_CTRL_RX_FIFO_CLR,
				b == `ETH_SMA_CTRL_MASTER_CLR, 1'b0, 1'b0};
			clear_counts();
			apb_write(`ETH_REG_SMA_CTRL, 32'h1 << b);
			@(negedge reg_clk);
			check_value($sformatf("sma_clr for bit %0d", b), sma_clr, exp);
			repeat (3) @(posedge reg_clk);
			check_value("sma_clr.tx_fifo cycles", sma_tx_cnt, exp.tx_fifo);
			check_value("sma_clr.rx_fifo cycles", sma_rx_cnt, exp.rx_fifo);
			check_value("sma_clr.master cycles", sma_master_cnt, exp.master);
		end
	endtask

	// pulse must show within 5 destination cycles of the access edge
	task automatic await_domain_clear(input logic rx_side);
		int n;
		n = 0;
		if (rx_side)
		begin
			while (rx_clr_cnt == 0 && n < 5)
			begin
				@(posedge pe_rx_clk);
				n = n + 1;
			end
			if (rx_clr_cnt == 0)
				report_failure("rx_logic_clr pulse did not arrive within 5 pe_rx_clk cycles");
			repeat (4) @(posedge pe_rx_clk);
		end
		else
		begin
			while (tx_clr_cnt == 0 && n < 5)
			begin
				@(posedge pe_tx_clk);
				n = n + 1;
			end
			if (tx_clr_cnt == 0)
				report_failure("tx_logic_clr pulse did not arrive within 5 pe_tx_clk cycles");
			repeat (4) @(posedge pe_tx_clk);
		end
	endtask

	task automatic test_domain_clears();
		clear_counts();
		apb_write(`ETH_REG_MAC_CTRL, 32'h1 << `ETH_MAC_CTRL_TX_LOGIC_CLR);
		await_domain_clear(1'b0);
		@(posedge reg_clk);
		check_value("tx_logic_clr pulses", tx_clr_cnt, 1);
		check_value("rx_logic_clr pulses", rx_clr_cnt, 0);
		apb_write(`ETH_REG_MAC_CTRL, 32'h1 << `ETH_MAC_CTRL_RX_LOGIC_CLR);
		await_domain_clear(1'b1);
		@(posedge reg_clk);
		check_value("rx_logic_clr pulses", rx_clr_cnt, 1);
		check_value("tx_logic_clr pulses", tx_clr_cnt, 1);
	endtask

	// ====================
	// main sequence
	// ====================

	initial
	begin
		reg_rstn    <= 1'b0;
		pe_tx_rstn  <= 1'b0;
		pe_rx_rstn  <= 1'b0;
		paddr       <= 32'h0;
		pwrite      <= 1'b0;
		psel        <= 1'b0;
		penable     <= 1'b0;
		pwdata      <= 32'h0;
		rx_data     <= 16'h0;
		tx_fifo_num <= 3'h0;
		rx_fifo_num <= 3'h0;
		int_sta     <= 6'h0;
		repeat (4) @(posedge reg_clk);
		reg_rstn   <= 1'b1;
		pe_tx_rstn <= 1'b1;
		pe_rx_rstn <= 1'b1;
		@(posedge reg_clk);
		test_reset_values();
		test_lone_penable();
		test_shadow_update();
		test_fifo_access();
		test_interrupts();
		test_sma_clears();
		test_domain_clears();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hdl/eth_regs_pkg.sv
hdl/eth_apb_slave.sv
hdl/eth_cfg_regs.sv
hdl/pulse_sync.sv
hdl/eth_clr_dispatch.sv
hdl/eth_regs_wrap.sv
sim/tb_eth_regs.sv
